//--- hw/xbar_pkg.sv
// OBI crossbar shared definitions

package xbar_pkg;

  // ========================================
  // widths and counts
  // ========================================
  localparam int ADDR_W = 32;
  localparam int DATA_W = 33;   // bit 32 is the tag bit
  localparam int BE_W   = 4;

  localparam int N_MSTR = 2;    // 0 cpu_d, 1 dbg
  localparam int N_TGT  = 4;

  // target indices
  localparam int TGT_DBGMEM = 0;
  localparam int TGT_IRAM   = 1;
  localparam int TGT_DRAM   = 2;
  localparam int TGT_EXT    = 3;  // default region

  // ========================================
  // address map, END is exclusive
  // ========================================
  localparam logic [ADDR_W-1:0] DBGMEM_BASE = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] DBGMEM_END  = 32'h0300_0000;
  localparam logic [ADDR_W-1:0] IRAM_BASE   = 32'h2004_0000;
  localparam logic [ADDR_W-1:0] IRAM_END    = 32'h200C_0000;
  localparam logic [ADDR_W-1:0] DRAM_BASE   = 32'h200F_0000;
  localparam logic [ADDR_W-1:0] DRAM_END    = 32'h2010_0000;

  typedef logic [N_TGT-1:0]  tgt_sel_t;   // one-hot target
  typedef logic [N_MSTR-1:0] mstr_sel_t;  // one-hot master

  // master request, held stable until gnt
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic              we;
  } obi_req_t;

  // valid only in the rvalid cycle
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;
  } obi_rsp_t;

  typedef struct packed {
    logic              en;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic              we;
    logic [BE_W-1:0]   be;
  } mem_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] rdata;   // one cycle after en
    logic              ready;   // same cycle as en
    logic              error;
  } mem_rsp_t;

endpackage

//--- hw/obi_addr_decoder.sv
// OBI master port decoder

`timescale 1ns/1ps

module obi_addr_decoder
  import xbar_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 rstn_i,

  // master side
  input  logic                 req_i,
  input  obi_req_t             addr_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output obi_rsp_t             rsp_o,

  // target side
  output tgt_sel_t             tgt_req_o,
  input  tgt_sel_t             tgt_gnt_i,
  input  tgt_sel_t             tgt_rvalid_i,
  input  obi_rsp_t [N_TGT-1:0] tgt_rsp_i
);

  tgt_sel_t tgt_dec;     // decoded target, zero when idle
  tgt_sel_t pending_q;   // target that still owes a response
  logic     rsp_done;
  logic     can_issue;

  function automatic logic in_range(
    input logic [ADDR_W-1:0] addr,
    input logic [ADDR_W-1:0] base,
    input logic [ADDR_W-1:0] lim
  );
    return (addr >= base) && (addr < lim);
  endfunction

  // ========================================
  // region decode
  // ========================================
  always_comb begin
    tgt_dec = '0;
    if (req_i) begin
      if (in_range(addr_i.addr, DBGMEM_BASE, DBGMEM_END)) begin
        tgt_dec[TGT_DBGMEM] = 1'b1;
      end else if (in_range(addr_i.addr, IRAM_BASE, IRAM_END)) begin
        tgt_dec[TGT_IRAM] = 1'b1;
      end else if (in_range(addr_i.addr, DRAM_BASE, DRAM_END)) begin
        tgt_dec[TGT_DRAM] = 1'b1;
      end else begin
        tgt_dec[TGT_EXT] = 1'b1;  // everything else goes external
      end
    end
  end

  // hold the request back while another target still owes a response
  assign rsp_done  = |(pending_q & tgt_rvalid_i);
  assign can_issue = (pending_q == '0) || (pending_q == tgt_dec) || rsp_done;
  assign tgt_req_o = can_issue ? tgt_dec : '0;

  assign gnt_o = |(tgt_gnt_i & tgt_req_o);

  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      pending_q <= '0;
    end else if (gnt_o) begin
      pending_q <= tgt_dec;
    end else if (rsp_done) begin
      pending_q <= '0;
    end
  end

  // response steering
  assign rvalid_o = rsp_done;

  always_comb begin
    rsp_o = '0;
    for (int t = 0; t < N_TGT; t++) begin
      if (pending_q[t]) begin
        rsp_o = tgt_rsp_i[t];
      end
    end
  end

endmodule

//--- hw/tcm_arbiter.sv
// per-target master arbiter

`timescale 1ns/1ps

module tcm_arbiter
  import xbar_pkg::*;
#(
  parameter int ARB_RR = 1   // 0 strict priority, 1 round robin
) (
  input  logic      clk_i,
  input  logic      rstn_i,
  input  mstr_sel_t req_i,
  input  logic      ready_i,
  output mstr_sel_t gnt_o
);

  mstr_sel_t winner;

  // isolate the lowest set bit
  function automatic mstr_sel_t lowest_one(input mstr_sel_t vec);
    mstr_sel_t neg;
    neg = ~vec + 1'b1;
    return vec & neg;
  endfunction

  if (ARB_RR == 0) begin : g_fixed

    // master 0 always wins
    assign winner = lowest_one(req_i);

  end else begin : g_rr

    mstr_sel_t last_q;    // last granted master
    mstr_sel_t mask_lo;   // last granted and below
    mstr_sel_t req_hi;
    mstr_sel_t req_lo;

    // one-hot at i gives bits i..0; empty history gives all ones
    assign mask_lo = mstr_sel_t'((last_q << 1) - 1'b1);
    assign req_hi  = req_i & ~mask_lo;
    assign req_lo  = req_i & mask_lo;

    always_comb begin
      if (req_hi != '0) begin
        winner = lowest_one(req_hi);
      end else begin
        winner = lowest_one(req_lo);  // wrap around
      end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
      if (!rstn_i) begin
        last_q <= '0;
      end else if (gnt_o != '0) begin
        last_q <= gnt_o;
      end
    end

  end

  // no grant while the memory is stalled
  assign gnt_o = ready_i ? winner : '0;

endmodule

//--- hw/tcm_port.sv
// memory target port

`timescale 1ns/1ps

module tcm_port
  import xbar_pkg::*;
#(
  parameter int ARB_RR = 1
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // master side
  input  mstr_sel_t             req_i,
  input  obi_req_t [N_MSTR-1:0] mreq_i,
  output mstr_sel_t             gnt_o,
  output logic                  rvalid_o,
  output obi_rsp_t              rsp_o,

  // memory side
  output mem_req_t              mem_req_o,
  input  mem_rsp_t              mem_rsp_i
);

  mstr_sel_t gnt;
  logic      rvalid_q;

  tcm_arbiter #(
    .ARB_RR (ARB_RR)
  ) i_tcm_arbiter (
    .clk_i   (clk_i),
    .rstn_i  (rstn_i),
    .req_i   (req_i),
    .ready_i (mem_rsp_i.ready),
    .gnt_o   (gnt)
  );

  assign gnt_o = gnt;

  // ========================================
  // request mux onto the memory bus
  // ========================================
  always_comb begin
    mem_req_o    = '0;
    mem_req_o.en = |gnt;
    for (int m = 0; m < N_MSTR; m++) begin
      mem_req_o.addr  = mem_req_o.addr  | (mreq_i[m].addr  & {ADDR_W{gnt[m]}});
      mem_req_o.wdata = mem_req_o.wdata | (mreq_i[m].wdata & {DATA_W{gnt[m]}});
      mem_req_o.be    = mem_req_o.be    | (mreq_i[m].be    & {BE_W{gnt[m]}});
      mem_req_o.we    = mem_req_o.we    | (mreq_i[m].we    & gnt[m]);
    end
  end

  // memory answers one cycle after en
  always_ff @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= |gnt;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rsp_o.rdata = mem_rsp_i.rdata;
  assign rsp_o.err   = mem_rsp_i.error;

endmodule

//--- hw/obi_xbar_top.sv
// OBI TCM crossbar top

`timescale 1ns/1ps

module obi_xbar_top
  import xbar_pkg::*;
#(
  parameter int ARB_RR = 1
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,

  // masters, 0 cpu_d and 1 dbg
  input  mstr_sel_t             mstr_req_i,
  input  obi_req_t [N_MSTR-1:0] mstr_obi_i,
  output mstr_sel_t             mstr_gnt_o,
  output mstr_sel_t             mstr_rvalid_o,
  output obi_rsp_t [N_MSTR-1:0] mstr_rsp_o,

  // memories, dbgmem / iram / dram / ext
  output mem_req_t [N_TGT-1:0]  mem_req_o,
  input  mem_rsp_t [N_TGT-1:0]  mem_rsp_i
);

  tgt_sel_t  [N_MSTR-1:0] dec_req;    // per decoder, one bit per target
  tgt_sel_t  [N_MSTR-1:0] dec_gnt;
  mstr_sel_t [N_TGT-1:0]  port_req;   // per port, one bit per master
  mstr_sel_t [N_TGT-1:0]  port_gnt;

  tgt_sel_t               tgt_rvalid;
  obi_rsp_t  [N_TGT-1:0]  tgt_rsp;

  // ========================================
  // decoder x target transpose
  // ========================================
  always_comb begin
    for (int t = 0; t < N_TGT; t++) begin
      for (int m = 0; m < N_MSTR; m++) begin
        port_req[t][m] = dec_req[m][t];
        dec_gnt[m][t]  = port_gnt[t][m];
      end
    end
  end

  // master side
  for (genvar m = 0; m < N_MSTR; m++) begin : g_mstr
    obi_addr_decoder i_obi_addr_decoder (
      .clk_i        (clk_i),
      .rstn_i       (rstn_i),
      .req_i        (mstr_req_i[m]),
      .addr_i       (mstr_obi_i[m]),
      .gnt_o        (mstr_gnt_o[m]),
      .rvalid_o     (mstr_rvalid_o[m]),
      .rsp_o        (mstr_rsp_o[m]),
      .tgt_req_o    (dec_req[m]),
      .tgt_gnt_i    (dec_gnt[m]),
      .tgt_rvalid_i (tgt_rvalid),
      .tgt_rsp_i    (tgt_rsp)
    );
  end

  // target side, request payload shared by all ports
  for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
    tcm_port #(
      .ARB_RR (ARB_RR)
    ) i_tcm_port (
      .clk_i     (clk_i),
      .rstn_i    (rstn_i),
      .req_i     (port_req[t]),
      .mreq_i    (mstr_obi_i),
      .gnt_o     (port_gnt[t]),
      .rvalid_o  (tgt_rvalid[t]),
      .rsp_o     (tgt_rsp[t]),
      .mem_req_o (mem_req_o[t]),
      .mem_rsp_i (mem_rsp_i[t])
    );
  end

endmodule

//--- tests/tb_obi_xbar.sv
// OBI crossbar testbench

`timescale 1ns/1ps

// behavioral TCM per target port
module mem_model
  import xbar_pkg::*;
#(
  parameter int IS_EXT = 0
) (
  input  logic     clk_i,
  input  logic     rstn_i,
  input  logic     ready_i,
  input  mem_req_t req_i,
  output mem_rsp_t rsp_o
);

  logic [DATA_W-1:0] store [logic [ADDR_W-1:0]];
  logic [DATA_W-1:0] rdata_q;
  logic              error_q;

  always @(posedge clk_i or negedge rstn_i) begin
    if (!rstn_i) begin
      rdata_q <= '0;
      error_q <= 1'b0;
    end else if (req_i.en) begin
      if (req_i.we) begin
        store[req_i.addr] = req_i.wdata;
        rdata_q <= '0;  // writes answer with zero
      end else if (store.exists(req_i.addr)) begin
        rdata_q <= store[req_i.addr];
      end else begin
        rdata_q <= '0;
      end
      error_q <= (IS_EXT != 0) && req_i.addr[2];
    end else begin
      rdata_q <= '0;
      error_q <= 1'b0;
    end
  end

  assign rsp_o.rdata = rdata_q;
  assign rsp_o.ready = ready_i;
  assign rsp_o.error = error_q;

endmodule

module tb_obi_xbar
  import xbar_pkg::*;
();

  localparam int          CLK_HALF        = 10;
  localparam int          RESET_CYCLES    = 8;
  localparam int          MAX_LINES       = 64;
  localparam int          CYCLES_PER_LINE = 40;
  localparam logic [31:0] SEED            = 32'hbc8a40af;

  logic                  clk;
  logic                  rstn;
  mstr_sel_t             mstr_req;
  obi_req_t [N_MSTR-1:0] mstr_obi;
  mstr_sel_t             mstr_gnt;
  mstr_sel_t             mstr_rvalid;
  obi_rsp_t [N_MSTR-1:0] mstr_rsp;
  mem_req_t [N_TGT-1:0]  mem_req;
  mem_rsp_t [N_TGT-1:0]  mem_rsp;
  tgt_sel_t              port_ready;

  // trace contents
  string             t_name  [MAX_LINES];
  int                t_start [MAX_LINES];
  int                t_mstr  [MAX_LINES];
  int                t_tgt   [MAX_LINES];
  logic              t_we    [MAX_LINES];
  logic              t_err   [MAX_LINES];
  logic [ADDR_W-1:0] t_addr  [MAX_LINES];
  logic [BE_W-1:0]   t_be    [MAX_LINES];
  logic [DATA_W-1:0] t_wdata [MAX_LINES];
  logic [DATA_W-1:0] t_rdata [MAX_LINES];
  int                n_lines;

  int          cur       [N_MSTR];  // line on the bus or -1 when idle
  int          nxt       [N_MSTR];  // where the next search starts
  int          prev_line [N_MSTR];  // granted last cycle
  int          last_win  [N_TGT];   // -1 before the first grant
  int          cyc;
  int          done_cnt;
  string       active_name;
  logic [31:0] rnd_state;

  obi_xbar_top #(
    .ARB_RR (1)
  ) i_obi_xbar_top (
    .clk_i         (clk),
    .rstn_i        (rstn),
    .mstr_req_i    (mstr_req),
    .mstr_obi_i    (mstr_obi),
    .mstr_gnt_o    (mstr_gnt),
    .mstr_rvalid_o (mstr_rvalid),
    .mstr_rsp_o    (mstr_rsp),
    .mem_req_o     (mem_req),
    .mem_rsp_i     (mem_rsp)
  );

  for (genvar t = 0; t < N_TGT; t++) begin : g_mem
    mem_model #(
      .IS_EXT (t == TGT_EXT)
    ) i_mem_model (
      .clk_i   (clk),
      .rstn_i  (rstn),
      .ready_i (port_ready[t]),
      .req_i   (mem_req[t]),
      .rsp_o   (mem_rsp[t])
    );
  end

  always #(CLK_HALF) clk = ~clk;

  // ========================================
  // helpers
  // ========================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  function automatic int next_line_of(input int m, input int from);
    for (int i = from; i < n_lines; i++) begin
      if (t_mstr[i] == m) begin
        return i;
      end
    end
    return -1;
  endfunction

  function automatic string line_name(input int idx);
    return (idx >= 0) ? t_name[idx] : "idle";
  endfunction

  task automatic stop_with_failure();
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [127:0] exp, input logic [127:0] act);
    $display("Mismatch in test %0s, %0s: expected %0h, actual %0h", test, what, exp, act);
    stop_with_failure();
  endtask

  task automatic read_trace();
    int                fd;
    int                n;
    int                start;
    int                mstr;
    int                we;
    int                tgt;
    int                err;
    string             line;
    string             name;
    logic [ADDR_W-1:0] addr;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] wdata;
    logic [DATA_W-1:0] rdata;
    n_lines = 0;
    fd = $fopen("tests/xbar_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file tests/xbar_trace.txt");
      stop_with_failure();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 1 && line[0] != "#") begin
        n = $sscanf(line, "%s %d %d %d %h %h %h %d %h %d",
                    name, start, mstr, we, addr, be, wdata, tgt, rdata, err);
        if (n != 10 || n_lines >= MAX_LINES) begin
          $display("trace line %0d is malformed or the trace is too long", n_lines);
          stop_with_failure();
        end
        t_name[n_lines]  = name;
        t_start[n_lines] = start;
        t_mstr[n_lines]  = mstr;
        t_we[n_lines]    = (we != 0);
        t_addr[n_lines]  = addr;
        t_be[n_lines]    = be;
        t_wdata[n_lines] = wdata;
        t_tgt[n_lines]   = tgt;
        t_rdata[n_lines] = rdata;
        t_err[n_lines]   = (err != 0);
        n_lines++;
      end
    end
    $fclose(fd);
  endtask

  // ========================================
  // reference model, checks and stimulus
  // ========================================
  always @(posedge clk) begin : cycle_step
    mstr_sel_t                   exp_gnt;
    tgt_sel_t                    exp_en;
    mstr_sel_t                   reqs;
    int                          win [N_TGT];
    int                          idx;
    logic                        stall;
    logic [ADDR_W+DATA_W+BE_W:0] exp_bus;
    logic [ADDR_W+DATA_W+BE_W:0] act_bus;
    if (rstn) begin
      // a pending response always lands in the cycle after its grant,
      // so a decoder never holds a request back
      exp_gnt = '0;
      exp_en  = '0;
      for (int t = 0; t < N_TGT; t++) begin
        reqs   = '0;
        win[t] = -1;
        for (int m = 0; m < N_MSTR; m++) begin
          if (cur[m] >= 0 && t_tgt[cur[m]] == t) begin
            reqs[m] = 1'b1;
          end
        end
        if (reqs != '0 && port_ready[t]) begin
          if (reqs == '1) begin
            win[t] = (last_win[t] == 0) ? 1 : 0;  // above the last winner or wrap
          end else begin
            win[t] = reqs[1] ? 1 : 0;
          end
          exp_gnt[win[t]] = 1'b1;
          exp_en[t]       = 1'b1;
        end
      end

      for (int m = 0; m < N_MSTR; m++) begin
        assert (mstr_gnt[m] == exp_gnt[m]) else begin
          report_mismatch(line_name(cur[m]), $sformatf("gnt of master %0d", m),
                          exp_gnt[m], mstr_gnt[m]);
        end
        assert (mstr_rvalid[m] == (prev_line[m] >= 0)) else begin
          report_mismatch(line_name(prev_line[m]), $sformatf("rvalid of master %0d", m),
                          prev_line[m] >= 0, mstr_rvalid[m]);
        end
        if (prev_line[m] >= 0) begin
          assert (mstr_rsp[m].rdata == t_rdata[prev_line[m]]) else begin
            report_mismatch(t_name[prev_line[m]], $sformatf("rdata of master %0d", m),
                            t_rdata[prev_line[m]], mstr_rsp[m].rdata);
          end
          assert (mstr_rsp[m].err == t_err[prev_line[m]]) else begin
            report_mismatch(t_name[prev_line[m]], $sformatf("err of master %0d", m),
                            t_err[prev_line[m]], mstr_rsp[m].err);
          end
        end
      end

      for (int t = 0; t < N_TGT; t++) begin
        assert (mem_req[t].en == exp_en[t]) else begin
          report_mismatch(active_name, $sformatf("en of port %0d", t),
                          exp_en[t], mem_req[t].en);
        end
        if (exp_en[t]) begin
          idx     = cur[win[t]];
          exp_bus = {t_addr[idx], t_wdata[idx], t_be[idx], t_we[idx]};
          act_bus = {mem_req[t].addr, mem_req[t].wdata, mem_req[t].be, mem_req[t].we};
          assert (act_bus == exp_bus) else begin
            report_mismatch(t_name[idx], $sformatf("memory request on port %0d", t),
                            exp_bus, act_bus);
          end
          last_win[t] = win[t];
        end
      end

      // retire granted lines, then put the next one on the bus
      for (int m = 0; m < N_MSTR; m++) begin
        prev_line[m] = -1;
        if (exp_gnt[m]) begin
          prev_line[m] = cur[m];
          cur[m]       = -1;
          done_cnt++;
        end
        if (cur[m] < 0) begin
          idx = next_line_of(m, nxt[m]);
          if (idx >= 0 && t_start[idx] <= cyc) begin
            cur[m]      = idx;
            nxt[m]      = idx + 1;
            active_name = t_name[idx];
          end
        end
        mstr_req[m] <= (cur[m] >= 0);
        if (cur[m] >= 0) begin
          mstr_obi[m].addr  <= t_addr[cur[m]];
          mstr_obi[m].be    <= t_be[cur[m]];
          mstr_obi[m].wdata <= t_wdata[cur[m]];
          mstr_obi[m].we    <= t_we[cur[m]];
        end
      end

      stall = 1'b0;
      for (int m = 0; m < N_MSTR; m++) begin
        if (cur[m] >= 0 && t_name[cur[m]] == "backpressure") begin
          stall = 1'b1;
        end
      end
      rnd_state = xorshift32(rnd_state);
      port_ready <= stall ? rnd_state[N_TGT-1:0] : '1;
      cyc++;
    end
  end

  // ========================================
  // run control
  // ========================================
  initial begin
    clk         = 1'b0;
    rstn        = 1'b0;
    mstr_req    = '0;
    mstr_obi    = '0;
    port_ready  = '1;
    rnd_state   = SEED;
    cyc         = 0;
    done_cnt    = 0;
    active_name = "reset";
    for (int m = 0; m < N_MSTR; m++) begin
      cur[m]       = -1;
      nxt[m]       = 0;
      prev_line[m] = -1;
    end
    for (int t = 0; t < N_TGT; t++) begin
      last_win[t] = -1;
    end
    read_trace();
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1;
    while (done_cnt < n_lines) @(negedge clk);
    repeat (2) @(negedge clk);  // last rvalid
    assert (mstr_rvalid == '0) else begin
      $display("a response was still outstanding after the last trace line");
      stop_with_failure();
    end
    $display("Finished with no errors");
    $finish;
  end

  // watchdog
  initial begin
    @(posedge rstn);
    repeat (CYCLES_PER_LINE * n_lines) @(posedge clk);
    $display("timeout: the trace did not complete within %0d cycles",
             CYCLES_PER_LINE * n_lines);
    stop_with_failure();
  end

endmodule

//--- tests/xbar_trace.txt
# name start master we addr be wdata tgt rdata err
# addr, be, wdata and rdata in hex; tgt 0 dbgmem, 1 iram, 2 dram, 3 ext
decode 0 0 1 00000000 f 000000001 0 000000000 0
decode 0 0 1 02fffffc f 000000002 0 000000000 0
decode 0 0 1 03000000 f 000000003 3 000000000 0
decode 0 0 1 20040000 f 000000004 1 000000000 0
decode 0 0 1 200bfffc f 000000005 1 000000000 0
decode 0 0 1 200c0000 f 000000006 3 000000000 0
decode 0 0 1 200f0000 f 000000007 2 000000000 0
decode 0 0 1 200ffff8 f 000000008 2 000000000 0
decode 0 0 1 20100000 f 000000009 3 000000000 0
decode 0 0 1 20040004 5 10000000a 1 000000000 0
decode 0 0 1 80000004 f 00000000b 3 000000000 1
decode 0 1 1 00001000 3 100001000 0 000000000 0
decode 0 1 1 20080000 c 0cafe0000 1 000000000 0
decode 0 1 1 40000008 f 012345678 3 000000000 0
decode 0 1 0 ff00000c f 000000000 3 000000000 1
wr_rd 40 0 0 00000000 f 000000000 0 000000001 0
wr_rd 40 0 1 200f0100 f 1deadbeef 2 000000000 0
wr_rd 40 0 0 200f0100 f 000000000 2 1deadbeef 0
wr_rd 40 0 1 200f0100 f 012345678 2 000000000 0
wr_rd 40 0 0 200f0100 f 000000000 2 012345678 0
wr_rd 40 0 0 80000004 f 000000000 3 00000000b 1
wr_rd 40 1 0 20040004 f 000000000 1 10000000a 0
wr_rd 40 1 1 00002000 f 0000000aa 0 000000000 0
wr_rd 40 1 0 00002000 f 000000000 0 0000000aa 0
rr 70 0 1 200f0200 f 000000010 2 000000000 0
rr 70 0 1 200f0204 f 000000011 2 000000000 0
rr 70 0 1 200f0208 f 000000012 2 000000000 0
rr 70 0 1 200f020c f 000000013 2 000000000 0
rr 70 0 0 200f0300 f 000000000 2 000000020 0
rr 70 1 1 200f0300 f 000000020 2 000000000 0
rr 70 1 1 200f0304 f 000000021 2 000000000 0
rr 70 1 1 200f0308 f 000000022 2 000000000 0
rr 70 1 1 200f030c f 000000023 2 000000000 0
backpressure 100 0 1 20050000 f 000000030 1 000000000 0
backpressure 100 0 1 c0000004 f 000000031 3 000000000 1
backpressure 100 0 0 c0000004 f 000000000 3 000000031 1
backpressure 100 1 1 00003000 f 000000040 0 000000000 0
backpressure 100 1 0 00003000 f 000000000 0 000000040 0
backpressure 100 1 0 40000008 f 000000000 3 012345678 0
switch 140 0 1 20060000 f 000000050 1 000000000 0
switch 140 0 0 200f0200 f 000000000 2 000000010 0
switch 140 0 0 20060000 f 000000000 1 000000050 0
switch 140 0 0 90000000 f 000000000 3 000000000 0
switch 140 1 1 200f5000 f 000000052 2 000000000 0
switch 140 1 0 20080000 f 000000000 1 0cafe0000 0

//--- sources.f
hw/xbar_pkg.sv
hw/obi_addr_decoder.sv
hw/tcm_arbiter.sv
hw/tcm_port.sv
hw/obi_xbar_top.sv
tests/tb_obi_xbar.sv

//--- Bender.yml
package:
  name: obi_tcm_xbar

dependencies: {}

sources:
  # package first, then leaf modules up to the top level
  - hw/xbar_pkg.sv
  - hw/obi_addr_decoder.sv
  - hw/tcm_arbiter.sv
  - hw/tcm_port.sv
  - hw/obi_xbar_top.sv

  # testbench
  - target: test
    files:
      - tests/tb_obi_xbar.sv
